// ==== dcache_wb.f ====
rtl/dcache_wb_pkg.sv
rtl/store_port.sv
rtl/write_buffer.sv
rtl/axi_lite_drain.sv
rtl/dcache_wb_top.sv
verif/axi_lite_mem_model.sv
verif/tb_dcache_wb.sv

// ==== Bender.yml ====
package:
  name: dcache_wb

sources:
  - rtl/dcache_wb_pkg.sv
  - rtl/store_port.sv
  - rtl/write_buffer.sv
  - rtl/axi_lite_drain.sv
  - rtl/dcache_wb_top.sv
  - target: test
    files:
      - verif/axi_lite_mem_model.sv
      - verif/tb_dcache_wb.sv

// ==== verif/tb_dcache_wb.sv ====
`timescale 1ns/1ns

module tb_dcache_wb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_ROWS     = 30;
    localparam int ROW_CYCLES   = 400;
    localparam int MEM_WORDS    = 256;
    localparam int MEM_IDX_W    = $clog2(MEM_WORDS);
    localparam int DEPTH_LOG2   = 2;
    localparam int DEPTH        = 2 ** DEPTH_LOG2;
    localparam logic [31:0] LFSR_SEED = 32'h52ba;
    localparam logic [31:0] ERR_ADDR  = 32'h0000_03a8;

    // table operations
    localparam logic [2:0] OP_STORE   = 3'd0;
    localparam logic [2:0] OP_LOAD    = 3'd1;
    localparam logic [2:0] OP_HOLD    = 3'd2;
    localparam logic [2:0] OP_RELEASE = 3'd3;
    localparam logic [2:0] OP_WAIT    = 3'd4;
    localparam logic [2:0] OP_FILL    = 3'd5;

    // exp_hit doubles as the expected bus error flag on wait rows
    typedef struct packed {
        logic [2:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic        exp_hit;
        logic [31:0] exp_data;
    } row_t;

    logic        clk;
    logic        rstn;
    logic        st_valid;
    logic        st_ready;
    logic [31:0] st_addr;
    logic [31:0] st_data;
    logic [3:0]  st_strb;
    logic        ld_check;
    logic [31:0] ld_addr;
    logic [3:0]  ld_strb;
    logic        ld_hit;
    logic [31:0] ld_data;
    logic        wb_empty;
    logic        bus_err;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        hold_resp;
    logic [31:0] aw_count;

    row_t        rows [NUM_ROWS];
    int          row_n;
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] written_q [$];
    logic        counting;
    logic [31:0] aw_base;

    dcache_wb_top #(
        .ADDR_W     (32),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_dut (
        .clk_i (clk), .rstn_i (rstn),
        .st_valid_i (st_valid), .st_ready_o (st_ready), .st_addr_i (st_addr),
        .st_data_i (st_data), .st_strb_i (st_strb),
        .ld_check_i (ld_check), .ld_addr_i (ld_addr), .ld_strb_i (ld_strb),
        .ld_hit_o (ld_hit), .ld_data_o (ld_data),
        .wb_empty_o (wb_empty), .bus_err_o (bus_err),
        .m_awvalid_o (awvalid), .m_awready_i (awready), .m_awaddr_o (awaddr),
        .m_wvalid_o (wvalid), .m_wready_i (wready), .m_wdata_o (wdata), .m_wstrb_o (wstrb),
        .m_bvalid_i (bvalid), .m_bready_o (bready), .m_bresp_i (bresp)
    );

    axi_lite_mem_model #(
        .MEM_WORDS (MEM_WORDS),
        .SEED      (LFSR_SEED)
    ) u_mem (
        .clk_i (clk), .rstn_i (rstn),
        .hold_resp_i (hold_resp), .err_addr_i (ERR_ADDR), .aw_count_o (aw_count),
        .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
        .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata), .wstrb_i (wstrb),
        .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_ROWS * ROW_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the table finished");
        $display("*** FAILED ***");
        $fatal(1, "run stopped by the watchdog");
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_on_error($sformatf("FAIL at %0t ns: %s expected 0x%08h, got 0x%08h",
                                    $time, name, exp, got));
        end
    endtask

    task automatic put_row(input logic [2:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input logic exp_hit, input logic [31:0] exp_data);
        rows[row_n] = '{op, addr, data, strb, exp_hit, exp_data};
        row_n++;
    endtask

    task automatic build_table();
        row_n = 0;
        // plain stores, drained without stalls
        put_row(OP_STORE,   32'h040, 32'h1122_3344, 4'hf, 1'b0, '0);
        put_row(OP_STORE,   32'h048, 32'ha5a5_a5a5, 4'h3, 1'b0, '0);
        put_row(OP_STORE,   32'h044, 32'h0102_0304, 4'hc, 1'b0, '0);
        put_row(OP_STORE,   32'h040, 32'hdead_beef, 4'h2, 1'b0, '0);
        put_row(OP_STORE,   32'h080, 32'hcafe_f00d, 4'hf, 1'b0, '0);
        put_row(OP_WAIT,    32'h000, 32'h0,         4'h0, 1'b0, '0);
        // head stalls on line 0x100 while line 0x200 coalesces
        put_row(OP_HOLD,    32'h000, 32'h0,         4'h0, 1'b0, '0);
        put_row(OP_STORE,   32'h100, 32'h0bad_f00d, 4'hf, 1'b0, '0);
        put_row(OP_STORE,   32'h204, 32'h1234_5678, 4'hf, 1'b0, '0);
        put_row(OP_STORE,   32'h20c, 32'h9abc_def0, 4'hf, 1'b0, '0);
        put_row(OP_STORE,   32'h204, 32'h00ff_00ff, 4'h5, 1'b0, '0);
        put_row(OP_STORE,   32'h208, 32'h5566_7788, 4'h3, 1'b0, '0);
        put_row(OP_LOAD,    32'h204, 32'h0,         4'hf, 1'b1, 32'h12ff_56ff);
        put_row(OP_LOAD,    32'h208, 32'h0,         4'h3, 1'b1, 32'h0000_7788);
        put_row(OP_LOAD,    32'h208, 32'h0,         4'hf, 1'b0, '0);
        put_row(OP_LOAD,    32'h210, 32'h0,         4'hf, 1'b0, '0);
        put_row(OP_LOAD,    32'h100, 32'h0,         4'hf, 1'b1, 32'h0bad_f00d);
        put_row(OP_LOAD,    32'h104, 32'h0,         4'h1, 1'b0, '0);
        put_row(OP_RELEASE, 32'h000, 32'h0,         4'h0, 1'b0, '0);
        put_row(OP_WAIT,    32'h000, 32'h0,         4'h0, 1'b0, '0);
        // back-pressure with distinct lines
        put_row(OP_HOLD,    32'h000, 32'h0,         4'h0, 1'b0, '0);
        put_row(OP_FILL,    32'h180, 32'h7e57_0000, 4'hf, 1'b0, '0);
        put_row(OP_RELEASE, 32'h000, 32'h0,         4'h0, 1'b0, '0);
        put_row(OP_WAIT,    32'h000, 32'h0,         4'h0, 1'b0, '0);
        // slave error on one word, flag is sticky
        put_row(OP_STORE,   ERR_ADDR, 32'h0f0f_0f0f, 4'hf, 1'b0, '0);
        put_row(OP_STORE,   32'h3a0, 32'h1357_9bdf, 4'hf, 1'b0, '0);
        put_row(OP_WAIT,    32'h000, 32'h0,         4'h0, 1'b1, '0);
        put_row(OP_STORE,   32'h044, 32'h2468_1357, 4'h6, 1'b0, '0);
        put_row(OP_WAIT,    32'h000, 32'h0,         4'h0, 1'b1, '0);
        put_row(OP_LOAD,    32'h044, 32'h0,         4'hf, 1'b0, '0);
    endtask

    function automatic logic [31:0] strb_mask(input logic [3:0] strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    // word addresses written since the last hold
    function automatic int count_distinct();
        int  n;
        bit  seen;
        n = 0;
        for (int i = 0; i < written_q.size(); i++) begin
            seen = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (written_q[j] == written_q[i]) begin
                    seen = 1'b1;
                end
            end
            if (!seen) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apply_store(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                ref_mem[addr[MEM_IDX_W+1:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
        written_q.push_back({addr[31:2], 2'b00});
    endtask

    task automatic send_store(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        logic taken;
        st_valid = 1'b1;
        st_addr  = addr;
        st_data  = data;
        st_strb  = strb;
        do begin
            @(negedge clk);
            taken = st_ready;
            @(posedge clk);
            #1;
        end while (!taken);
        st_valid = 1'b0;
        apply_store(addr, data, strb);
    endtask

    task automatic run_load(input row_t r);
        logic [31:0] mask;
        mask = strb_mask(r.strb);
        // let earlier stores settle into the buffer
        idle_cycles(2);
        ld_check = 1'b1;
        ld_addr  = r.addr;
        ld_strb  = r.strb;
        idle_cycles(1);
        ld_check = 1'b0;
        @(negedge clk);
        check_value("ld_hit_o", ld_hit, r.exp_hit);
        if (r.exp_hit) begin
            check_value("ld_data_o", ld_data & mask, r.exp_data & mask);
        end
        idle_cycles(1);
    endtask

    task automatic run_fill(input row_t r);
        int          taken_n;
        logic        ready;
        logic [31:0] addr;
        logic [31:0] data;
        taken_n = 0;
        ready   = 1'b1;
        while (ready && taken_n < DEPTH + 2) begin
            addr     = r.addr + 32'(taken_n * 16);
            data     = r.data ^ 32'(taken_n);
            st_valid = 1'b1;
            st_addr  = addr;
            st_data  = data;
            st_strb  = r.strb;
            @(negedge clk);
            ready = st_ready;
            @(posedge clk);
            #1;
            if (ready) begin
                apply_store(addr, data, r.strb);
                taken_n++;
            end
        end
        st_valid = 1'b0;
        assert (!ready) else begin
            stop_on_error($sformatf("st_ready_o still high after %0d stores with responses held",
                                    taken_n));
        end
    endtask

    task automatic run_wait(input row_t r);
        logic empty;
        idle_cycles(2);
        do begin
            @(negedge clk);
            empty = wb_empty;
            @(posedge clk);
            #1;
        end while (!empty);
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value($sformatf("u_mem.mem[0x%03h]", i * 4), u_mem.mem[i], ref_mem[i]);
        end
        check_value("bus_err_o", bus_err, r.exp_hit);
        if (counting) begin
            check_value("AW handshakes", aw_count - aw_base, count_distinct());
            counting = 1'b0;
        end
    endtask

    initial begin
        rstn      = 1'b0;
        st_valid  = 1'b0;
        st_addr   = '0;
        st_data   = '0;
        st_strb   = '0;
        ld_check  = 1'b0;
        ld_addr   = '0;
        ld_strb   = '0;
        hold_resp = 1'b0;
        counting  = 1'b0;
        aw_base   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = 32'hc3a5_0000 ^ (i * 4);
        end
        build_table();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_value("wb_empty_o", wb_empty, 1'b1);
        check_value("st_ready_o", st_ready, 1'b1);
        check_value("m_awvalid_o", awvalid, 1'b0);
        check_value("m_wvalid_o", wvalid, 1'b0);
        check_value("m_bready_o", bready, 1'b0);
        check_value("ld_hit_o", ld_hit, 1'b0);
        check_value("bus_err_o", bus_err, 1'b0);
        idle_cycles(1);

        for (int r = 0; r < NUM_ROWS; r++) begin
            case (rows[r].op)
                OP_STORE: send_store(rows[r].addr, rows[r].data, rows[r].strb);
                OP_LOAD:  run_load(rows[r]);
                OP_HOLD: begin
                    hold_resp = 1'b1;
                    aw_base   = aw_count;
                    counting  = 1'b1;
                    written_q.delete();
                    idle_cycles(1);
                end
                OP_RELEASE: begin
                    hold_resp = 1'b0;
                    idle_cycles(1);
                end
                OP_WAIT:  run_wait(rows[r]);
                OP_FILL:  run_fill(rows[r]);
                default:  stop_on_error($sformatf("unknown operation in table row %0d", r));
            endcase
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== verif/axi_lite_mem_model.sv ====
`timescale 1ns/1ns

module axi_lite_mem_model #(
    parameter int unsigned MEM_WORDS = 256,
    parameter logic [31:0] SEED      = 32'h52ba
) (
    input  logic        clk_i,
    input  logic        rstn_i,

    // test controls
    input  logic        hold_resp_i,
    input  logic [31:0] err_addr_i,
    output logic [31:0] aw_count_o,

    // AXI4-Lite write slave
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] awaddr_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    output logic        bvalid_o,
    input  logic        bready_i,
    output logic [1:0]  bresp_o
);

    localparam int unsigned IDX_W = $clog2(MEM_WORDS);

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] lfsr_q;
    logic        aw_gate_q;
    logic        w_gate_q;
    logic        aw_have_q;
    logic        w_have_q;
    logic [31:0] addr_q;
    logic [31:0] data_q;
    logic [3:0]  strb_q;

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // initial contents follow the byte address of each word
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hc3a5_0000 ^ (i * 4);
        end
    end

    assign awready_o = !aw_have_q && aw_gate_q;
    assign wready_o  = !w_have_q && w_gate_q;

    always @(posedge clk_i) begin : bus_side
        logic [31:0] s1;
        logic [31:0] s2;
        // two bits per cycle, one step each
        s1 = lfsr_next(lfsr_q);
        s2 = lfsr_next(s1);
        if (!rstn_i) begin
            lfsr_q     <= SEED;
            aw_gate_q  <= 1'b0;
            w_gate_q   <= 1'b0;
            aw_have_q  <= 1'b0;
            w_have_q   <= 1'b0;
            bvalid_o   <= 1'b0;
            bresp_o    <= 2'b00;
            aw_count_o <= '0;
        end else begin
            lfsr_q    <= s2;
            aw_gate_q <= s1[0];
            w_gate_q  <= s2[0];
            if (awvalid_i && awready_o) begin
                aw_have_q  <= 1'b1;
                addr_q     <= awaddr_i;
                aw_count_o <= aw_count_o + 1;
            end
            if (wvalid_i && wready_o) begin
                w_have_q <= 1'b1;
                data_q   <= wdata_i;
                strb_q   <= wstrb_i;
            end
            // write lands together with the response, which the hold can delay
            if (aw_have_q && w_have_q && !bvalid_o && !hold_resp_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb_q[b]) begin
                        mem[addr_q[IDX_W+1:2]][8*b +: 8] <= data_q[8*b +: 8];
                    end
                end
                bvalid_o  <= 1'b1;
                bresp_o   <= (addr_q == err_addr_i) ? 2'b10 : 2'b00;
                aw_have_q <= 1'b0;
                w_have_q  <= 1'b0;
            end else if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/dcache_wb_top.sv ====
`timescale 1ns/1ns

module dcache_wb_top
    import dcache_wb_pkg::*;
#(
    parameter int unsigned ADDR_W     = 32,
    parameter int unsigned DEPTH_LOG2 = 2
) (
    input  logic              clk_i,
    input  logic              rstn_i,

    // store request
    input  logic              st_valid_i,
    output logic              st_ready_o,
    input  logic [ADDR_W-1:0] st_addr_i,
    input  logic [WORD_W-1:0] st_data_i,
    input  logic [STRB_W-1:0] st_strb_i,

    // load probe
    input  logic              ld_check_i,
    input  logic [ADDR_W-1:0] ld_addr_i,
    input  logic [STRB_W-1:0] ld_strb_i,
    output logic              ld_hit_o,
    output logic [WORD_W-1:0] ld_data_o,

    // status
    output logic              wb_empty_o,
    output logic              bus_err_o,

    // AXI4-Lite write master
    output logic              m_awvalid_o,
    input  logic              m_awready_i,
    output logic [ADDR_W-1:0] m_awaddr_o,
    output logic              m_wvalid_o,
    input  logic              m_wready_i,
    output logic [WORD_W-1:0] m_wdata_o,
    output logic [STRB_W-1:0] m_wstrb_o,
    input  logic              m_bvalid_i,
    output logic              m_bready_o,
    input  logic [1:0]        m_bresp_i
);

    localparam int unsigned LINE_AW = ADDR_W - LINE_OFS_W;

    // store port to write buffer
    logic                   req_valid;
    logic                   req_ready;
    logic [LINE_AW-1:0]     req_line_addr;
    wb_line_u               req_data;
    logic [LINE_STRB_W-1:0] req_strb;

    // write buffer to drain
    logic                   head_valid;
    logic [LINE_AW-1:0]     head_line_addr;
    wb_line_u               head_data;
    logic [LINE_STRB_W-1:0] head_strb;
    logic                   head_busy;
    logic                   head_pop;

    store_port #(
        .ADDR_W (ADDR_W)
    ) u_store_port (
        .clk_i, .rstn_i,
        .st_valid_i, .st_ready_o, .st_addr_i, .st_data_i, .st_strb_i,
        .req_valid_o (req_valid), .req_ready_i (req_ready),
        .req_line_addr_o (req_line_addr), .req_data_o (req_data), .req_strb_o (req_strb)
    );

    write_buffer #(
        .ADDR_W     (ADDR_W),
        .DEPTH_LOG2 (DEPTH_LOG2)
    ) u_write_buffer (
        .clk_i, .rstn_i,
        .req_valid_i (req_valid), .req_ready_o (req_ready),
        .req_line_addr_i (req_line_addr), .req_data_i (req_data), .req_strb_i (req_strb),
        .ld_check_i, .ld_addr_i, .ld_strb_i, .ld_hit_o, .ld_data_o,
        .head_valid_o (head_valid), .head_line_addr_o (head_line_addr),
        .head_data_o (head_data), .head_strb_o (head_strb),
        .head_busy_i (head_busy), .head_pop_i (head_pop),
        .empty_o (wb_empty_o)
    );

    axi_lite_drain #(
        .ADDR_W (ADDR_W)
    ) u_drain (
        .clk_i, .rstn_i,
        .head_valid_i (head_valid), .head_line_addr_i (head_line_addr),
        .head_data_i (head_data), .head_strb_i (head_strb),
        .head_busy_o (head_busy), .head_pop_o (head_pop),
        .bus_err_o,
        .m_awvalid_o, .m_awready_i, .m_awaddr_o,
        .m_wvalid_o, .m_wready_i, .m_wdata_o, .m_wstrb_o,
        .m_bvalid_i, .m_bready_o, .m_bresp_i
    );

endmodule

// ==== rtl/axi_lite_drain.sv ====
`timescale 1ns/1ns

module axi_lite_drain
    import dcache_wb_pkg::*;
#(
    parameter int unsigned ADDR_W = 32
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,

    // head entry of the write buffer
    input  logic                         head_valid_i,
    input  logic [ADDR_W-LINE_OFS_W-1:0] head_line_addr_i,
    input  wb_line_u                     head_data_i,
    input  logic [LINE_STRB_W-1:0]       head_strb_i,
    output logic                         head_busy_o,
    output logic                         head_pop_o,

    output logic                         bus_err_o,

    // AXI4-Lite write master
    output logic                         m_awvalid_o,
    input  logic                         m_awready_i,
    output logic [ADDR_W-1:0]            m_awaddr_o,
    output logic                         m_wvalid_o,
    input  logic                         m_wready_i,
    output logic [WORD_W-1:0]            m_wdata_o,
    output logic [STRB_W-1:0]            m_wstrb_o,
    input  logic                         m_bvalid_i,
    output logic                         m_bready_o,
    input  logic [1:0]                   m_bresp_i
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_SEND = 2'd1;
    localparam logic [1:0] S_RESP = 2'd2;
    localparam logic [1:0] S_POP  = 2'd3;

    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [1:0]            state_q;
    logic [WORD_OFS_W-1:0] word_idx_q;
    logic                  aw_done_q;
    logic                  w_done_q;
    logic                  err_q;

    logic                  word_dirty;
    logic                  last_word;
    logic                  aw_fire;
    logic                  w_fire;
    logic                  beat_done;

    assign word_dirty = |head_strb_i[word_idx_q*STRB_W +: STRB_W];
    assign last_word  = (word_idx_q == WORD_OFS_W'(WORDS_PER_LINE - 1));

    // AW and W rise together, each drops on its own handshake
    assign m_awvalid_o = (state_q == S_SEND) && word_dirty && !aw_done_q;
    assign m_wvalid_o  = (state_q == S_SEND) && word_dirty && !w_done_q;
    assign aw_fire     = m_awvalid_o && m_awready_i;
    assign w_fire      = m_wvalid_o && m_wready_i;
    assign beat_done   = (aw_done_q || aw_fire) && (w_done_q || w_fire);

    // payload read straight from the head, which is frozen while busy
    assign m_awaddr_o = {head_line_addr_i, word_idx_q, 2'b00};
    assign m_wdata_o  = head_data_i.words[word_idx_q];
    assign m_wstrb_o  = head_strb_i[word_idx_q*STRB_W +: STRB_W];
    assign m_bready_o = (state_q == S_RESP);

    assign head_busy_o = (state_q != S_IDLE);
    assign head_pop_o  = (state_q == S_POP);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= S_IDLE;
            word_idx_q <= '0;
            aw_done_q  <= 1'b0;
            w_done_q   <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    word_idx_q <= '0;
                    if (head_valid_i) begin
                        state_q <= S_SEND;
                    end
                end
                S_SEND: begin
                    if (!word_dirty) begin
                        // clean word, nothing to write
                        if (last_word) begin
                            state_q <= S_POP;
                        end else begin
                            word_idx_q <= word_idx_q + 1'b1;
                        end
                    end else if (beat_done) begin
                        state_q   <= S_RESP;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                    end else begin
                        aw_done_q <= aw_done_q || aw_fire;
                        w_done_q  <= w_done_q || w_fire;
                    end
                end
                S_RESP: begin
                    if (m_bvalid_i) begin
                        if (last_word) begin
                            state_q <= S_POP;
                        end else begin
                            word_idx_q <= word_idx_q + 1'b1;
                            state_q    <= S_SEND;
                        end
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // sticky error flag
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            err_q <= 1'b0;
        end else if (m_bready_o && m_bvalid_i && m_bresp_i == RESP_SLVERR) begin
            err_q <= 1'b1;
        end
    end

    assign bus_err_o = err_q;

    // AXI payloads hold while waiting for ready
    a_aw_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        m_awvalid_o && !m_awready_i |=> m_awvalid_o && $stable(m_awaddr_o));

    a_w_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        m_wvalid_o && !m_wready_i |=> m_wvalid_o && $stable(m_wdata_o) && $stable(m_wstrb_o));

endmodule

// ==== rtl/write_buffer.sv ====
`timescale 1ns/1ns

module write_buffer
    import dcache_wb_pkg::*;
#(
    parameter int unsigned ADDR_W     = 32,
    parameter int unsigned DEPTH_LOG2 = 2
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,

    // request from the store port
    input  logic                         req_valid_i,
    output logic                         req_ready_o,
    input  logic [ADDR_W-LINE_OFS_W-1:0] req_line_addr_i,
    input  wb_line_u                     req_data_i,
    input  logic [LINE_STRB_W-1:0]       req_strb_i,

    // load probe
    input  logic                         ld_check_i,
    input  logic [ADDR_W-1:0]            ld_addr_i,
    input  logic [STRB_W-1:0]            ld_strb_i,
    output logic                         ld_hit_o,
    output logic [WORD_W-1:0]            ld_data_o,

    // oldest entry towards the drain
    output logic                         head_valid_o,
    output logic [ADDR_W-LINE_OFS_W-1:0] head_line_addr_o,
    output wb_line_u                     head_data_o,
    output logic [LINE_STRB_W-1:0]       head_strb_o,
    input  logic                         head_busy_i,
    input  logic                         head_pop_i,

    output logic                         empty_o
);

    localparam int unsigned LINE_AW = ADDR_W - LINE_OFS_W;
    localparam int unsigned DEPTH   = 2 ** DEPTH_LOG2;

    // entry storage
    logic [LINE_AW-1:0]     line_addr_q [DEPTH];
    wb_line_u               data_q      [DEPTH];
    logic [LINE_STRB_W-1:0] strb_q      [DEPTH];
    logic [DEPTH-1:0]       valid_q;

    // pointers carry one extra wrap bit
    logic [DEPTH_LOG2:0]    wr_ptr_q;
    logic [DEPTH_LOG2:0]    rd_ptr_q;
    logic [DEPTH_LOG2-1:0]  wr_idx;
    logic [DEPTH_LOG2-1:0]  rd_idx;
    logic                   full;

    logic [DEPTH-1:0]       merge_hit;
    logic                   merge_any;
    logic [DEPTH_LOG2-1:0]  merge_idx;
    wb_line_u               merged_data;
    logic                   do_merge;
    logic                   do_append;

    logic [LINE_AW-1:0]     ld_line;
    logic [WORD_OFS_W-1:0]  ld_word;
    logic [LINE_STRB_W-1:0] ld_line_strb;
    logic                   ld_found;
    logic [DEPTH_LOG2-1:0]  ld_idx;
    logic                   ld_hit_q;
    logic [WORD_W-1:0]      ld_data_q;

    assign wr_idx  = wr_ptr_q[DEPTH_LOG2-1:0];
    assign rd_idx  = rd_ptr_q[DEPTH_LOG2-1:0];
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full    = (wr_ptr_q[DEPTH_LOG2] != rd_ptr_q[DEPTH_LOG2]) && (wr_idx == rd_idx);

    // look for a pending entry of the same line, the head is locked while draining
    always_comb begin
        merge_hit = '0;
        merge_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (valid_q[i] && line_addr_q[i] == req_line_addr_i
                    && !(head_busy_i && DEPTH_LOG2'(i) == rd_idx)) begin
                merge_hit[i] = 1'b1;
                merge_idx    = DEPTH_LOG2'(i);
            end
        end
    end

    assign merge_any   = |merge_hit;
    assign req_ready_o = merge_any || !full;
    assign do_merge    = req_valid_i && req_ready_o && merge_any;
    assign do_append   = req_valid_i && req_ready_o && !merge_any;

    // new bytes replace old ones under the request strobes
    always_comb begin
        merged_data = data_q[merge_idx];
        for (int b = 0; b < LINE_STRB_W; b++) begin
            if (req_strb_i[b]) begin
                merged_data.bytes[b] = req_data_i.bytes[b];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_append) begin
            line_addr_q[wr_idx] <= req_line_addr_i;
            data_q[wr_idx]      <= req_data_i;
            strb_q[wr_idx]      <= req_strb_i;
        end else if (do_merge) begin
            data_q[merge_idx]   <= merged_data;
            strb_q[merge_idx]   <= strb_q[merge_idx] | req_strb_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            valid_q  <= '0;
        end else begin
            if (do_append) begin
                wr_ptr_q        <= wr_ptr_q + 1'b1;
                valid_q[wr_idx] <= 1'b1;
            end
            if (head_pop_i) begin
                rd_ptr_q        <= rd_ptr_q + 1'b1;
                valid_q[rd_idx] <= 1'b0;
            end
        end
    end

    assign head_valid_o     = !empty_o;
    assign head_line_addr_o = line_addr_q[rd_idx];
    assign head_data_o      = data_q[rd_idx];
    assign head_strb_o      = strb_q[rd_idx];

    // load probe in line coordinates
    assign ld_line      = ld_addr_i[ADDR_W-1:LINE_OFS_W];
    assign ld_word      = ld_addr_i[LINE_OFS_W-1:LINE_OFS_W-WORD_OFS_W];
    assign ld_line_strb = LINE_STRB_W'(ld_strb_i) << (STRB_W * ld_word);

    // walk back from the write pointer so the youngest match wins
    always_comb begin
        logic [DEPTH_LOG2-1:0] scan_idx;
        ld_found = 1'b0;
        ld_idx   = '0;
        for (int k = 1; k <= DEPTH; k++) begin
            scan_idx = wr_idx - DEPTH_LOG2'(k);
            if (!ld_found && valid_q[scan_idx] && line_addr_q[scan_idx] == ld_line) begin
                ld_found = 1'b1;
                ld_idx   = scan_idx;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ld_hit_q <= 1'b0;
        end else begin
            ld_hit_q <= ld_check_i && ld_found
                        && ((strb_q[ld_idx] & ld_line_strb) == ld_line_strb);
        end
    end

    always_ff @(posedge clk_i) begin
        if (ld_check_i) begin
            ld_data_q <= data_q[ld_idx].words[ld_word];
        end
    end

    assign ld_hit_o  = ld_hit_q;
    assign ld_data_o = ld_data_q;

    // an append must land in a free slot, valid bits and pointers agree
    a_no_append_full: assert property (@(posedge clk_i) disable iff (!rstn_i)
        do_append |-> !valid_q[wr_idx]);

    // the drain only pops a line that exists
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rstn_i)
        head_pop_i |-> !empty_o);

endmodule

// ==== rtl/store_port.sv ====
`timescale 1ns/1ns

module store_port
    import dcache_wb_pkg::*;
#(
    parameter int unsigned ADDR_W = 32
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,

    // core store request
    input  logic                         st_valid_i,
    output logic                         st_ready_o,
    input  logic [ADDR_W-1:0]            st_addr_i,
    input  logic [WORD_W-1:0]            st_data_i,
    input  logic [STRB_W-1:0]            st_strb_i,

    // line-aligned request towards the write buffer
    output logic                         req_valid_o,
    input  logic                         req_ready_i,
    output logic [ADDR_W-LINE_OFS_W-1:0] req_line_addr_o,
    output wb_line_u                     req_data_o,
    output logic [LINE_STRB_W-1:0]       req_strb_o
);

    localparam int unsigned LINE_AW = ADDR_W - LINE_OFS_W;

    logic                   req_valid_q;
    logic [LINE_AW-1:0]     line_addr_q;
    wb_line_u               data_q;
    logic [LINE_STRB_W-1:0] strb_q;

    logic [WORD_OFS_W-1:0]  word_sel;
    wb_line_u               data_placed;
    logic [LINE_STRB_W-1:0] strb_placed;
    logic                   accept;

    // holding register is free, or it empties this cycle
    assign st_ready_o = !req_valid_q || req_ready_i;
    assign accept     = st_valid_i && st_ready_o;

    // byte offset bits 1:0 are dropped, strobes carry the byte lanes
    assign word_sel = st_addr_i[LINE_OFS_W-1:LINE_OFS_W-WORD_OFS_W];

    always_comb begin
        data_placed = '0;
        data_placed.words[word_sel] = st_data_i;
        strb_placed = LINE_STRB_W'(st_strb_i) << (STRB_W * word_sel);
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            req_valid_q <= 1'b0;
        end else if (accept) begin
            req_valid_q <= 1'b1;
        end else if (req_ready_i) begin
            req_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            line_addr_q <= st_addr_i[ADDR_W-1:LINE_OFS_W];
            data_q      <= data_placed;
            strb_q      <= strb_placed;
        end
    end

    assign req_valid_o     = req_valid_q;
    assign req_line_addr_o = line_addr_q;
    assign req_data_o      = data_q;
    assign req_strb_o      = strb_q;

    // a stalled request keeps its payload until the buffer takes it
    a_req_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_line_addr_o)
            && $stable(req_data_o) && $stable(req_strb_o));

endmodule

// ==== rtl/dcache_wb_pkg.sv ====
package dcache_wb_pkg;

    // bus word geometry
    parameter int unsigned WORD_W = 32;
    parameter int unsigned STRB_W = WORD_W / 8;

    // line geometry, fixed at four words
    parameter int unsigned WORDS_PER_LINE = 4;
    parameter int unsigned LINE_W = WORD_W * WORDS_PER_LINE;
    parameter int unsigned LINE_STRB_W = LINE_W / 8;

    // byte address bits 3:2 pick the word inside the line
    parameter int unsigned WORD_OFS_W = $clog2(WORDS_PER_LINE);
    parameter int unsigned LINE_OFS_W = $clog2(LINE_STRB_W);

    // one line seen as words or as bytes
    typedef union packed {
        logic [WORDS_PER_LINE-1:0][WORD_W-1:0] words;
        logic [LINE_STRB_W-1:0][7:0]           bytes;
    } wb_line_u;

endpackage
